/* Makefile */
# Verilator build and run for the SPI slave testbench

TOP  := tb_spi_wb_top
SRCS := $(shell grep -v '^+' filelist.f)

obj_dir/V$(TOP): filelist.f $(SRCS)
	verilator --binary --timing --assert --timescale 1ns/100ps \
		--top-module $(TOP) -f filelist.f

run: obj_dir/V$(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "Test completed successfully" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean

/* filelist.f */
logic/spi_pkg.sv
logic/wb_pkg.sv
logic/spi_edge_sync.sv
logic/spi_slave.sv
logic/spi_wb_regs.sv
logic/spi_wb_top.sv
verification/tb_spi_wb_top.sv

/* logic/spi_edge_sync.sv */
// Brings cs and sclk into the sys_clk domain and turns them into strobes.
// frame_start/frame_end follow cs edges; sample/shift follow sclk per CPOL/CPHA.
// Pin edge to strobe latency is 3 sys_clk cycles.
`default_nettype none

module spi_edge_sync #(
	parameter bit CPOL = 1'b1,                            // sclk idle level
	parameter bit CPHA = 1'b1                             // 0: sample leading edge, 1: trailing
) (
	input  logic sys_clk,
	input  logic sys_rst_n,
	input  logic cs,                                      // active low, async
	input  logic sclk,                                    // async
	output logic cs_active,
	output logic frame_start,
	output logic frame_end,
	output logic sample_edge,
	output logic shift_edge
);

	// modes 0 and 3 sample on rising, 1 and 2 on falling
	localparam bit sample_on_rise = (CPOL == CPHA);

	logic cs_meta, cs_sync, cs_hist;                      // cs pipeline
	logic sclk_meta, sclk_sync, sclk_hist;                // sclk pipeline
	logic sclk_rise, sclk_fall;

	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n) begin
			cs_meta   <= 1'b1;                            // deselected
			cs_sync   <= 1'b1;
			cs_hist   <= 1'b1;
			sclk_meta <= CPOL;                            // idle level
			sclk_sync <= CPOL;
			sclk_hist <= CPOL;
		end else begin
			cs_meta   <= cs;
			cs_sync   <= cs_meta;
			cs_hist   <= cs_sync;
			sclk_meta <= sclk;
			sclk_sync <= sclk_meta;
			sclk_hist <= sclk_sync;
		end
	end

	assign sclk_rise = sclk_sync & ~sclk_hist;
	assign sclk_fall = ~sclk_sync & sclk_hist;
	assign cs_active = ~cs_hist;                          // lines up with frame strobes

	// registered strobes, sclk gated while cs high
	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n) begin
			frame_start <= 1'b0;
			frame_end   <= 1'b0;
			sample_edge <= 1'b0;
			shift_edge  <= 1'b0;
		end else begin
			frame_start <= cs_hist & ~cs_sync;            // cs fell
			frame_end   <= ~cs_hist & cs_sync;            // cs rose
			sample_edge <= ~cs_sync & (sample_on_rise ? sclk_rise : sclk_fall);
			shift_edge  <= ~cs_sync & (sample_on_rise ? sclk_fall : sclk_rise);
		end
	end

	a_frame_excl: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		!(frame_start && frame_end));

endmodule

`default_nettype wire

/* logic/spi_pkg.sv */
// SPI side definitions shared by the edge synchronizer and the shift engine.
// Import inside a module body; use scoped names in port lists.
`default_nettype none

package spi_pkg;

	localparam int spi_bits_per_byte = 8;                 // one frame carries one byte

	// one data byte as seen on mosi/miso
	typedef logic [spi_bits_per_byte-1:0] spi_byte_t;

	// completed sclk edges in a byte, 0..16
	typedef logic [4:0] spi_bit_cnt_t;

	// two sclk edges per bit
	localparam spi_bit_cnt_t spi_edges_per_byte = spi_bit_cnt_t'(2 * spi_bits_per_byte);

	// shift engine states
	typedef enum logic [2:0] {
		st_idle      = 3'd0,                              // waiting for cs to drop
		st_wait_edge = 3'd1,                              // waiting for next phase edge
		st_edge      = 3'd2,                              // acting on one edge
		st_last_half = 3'd3,                              // last edge seen
		st_done      = 3'd4,                              // byte_done pulse
		st_finish    = 3'd5                               // back to idle
	} spi_state_e;

endpackage

`default_nettype wire

/* logic/spi_slave.sv */
// Byte shift engine for the SPI slave.
// Counts the 16 sclk phase edges of a frame, samples mosi, shifts miso,
// and pulses byte_done once the byte is complete. cs high aborts.
`default_nettype none

module spi_slave #(
	parameter bit CPHA = 1'b1                             // 1: first leading edge only shifts
) (
	input  logic               sys_clk,
	input  logic               sys_rst_n,
	input  logic               cs_active,
	input  logic               frame_start,
	input  logic               frame_end,
	input  logic               sample_edge,
	input  logic               shift_edge,
	input  logic               mosi,
	input  spi_pkg::spi_byte_t tx_byte,
	output logic               miso,
	output logic               byte_done,
	output spi_pkg::spi_byte_t rx_byte
);

	import spi_pkg::*;

	localparam spi_bit_cnt_t last_edge = spi_edges_per_byte - 5'd1;

	spi_state_e   state;
	spi_bit_cnt_t edge_cnt;                               // edges handled so far
	spi_byte_t    mosi_shift;                             // receive shifter
	spi_byte_t    miso_shift;                             // transmit shifter

	logic lead_edge;                                      // first edge of a sclk period
	logic trail_edge;                                     // second edge of a sclk period
	logic odd_edge;
	logic edge_seen;
	logic abort;
	logic sample_now;
	logic shift_now;

	// for CPHA=1 the leading edge is the shift edge
	assign lead_edge  = CPHA ? shift_edge : sample_edge;
	assign trail_edge = CPHA ? sample_edge : shift_edge;

	assign odd_edge  = edge_cnt[0];
	assign edge_seen = odd_edge ? trail_edge : lead_edge; // alternate phases
	assign abort     = !cs_active || frame_end;           // cs high kills the byte

	// act on the edge held in st_edge, edge_cnt still the old count
	assign sample_now = (state == st_edge) && (odd_edge == CPHA);
	assign shift_now  = (state == st_edge) && (odd_edge != CPHA) &&
		!(CPHA && edge_cnt == '0);                        // CPHA=1 skips very first edge

	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n) begin
			state <= st_idle;
		end else if (abort) begin
			state <= st_idle;
		end else begin
			case (state)
				st_idle: begin
					if (frame_start)
						state <= st_wait_edge;            // one byte per frame
				end
				st_wait_edge: begin
					if (edge_seen)
						state <= st_edge;
				end
				st_edge: begin
					if (edge_cnt == last_edge)
						state <= st_last_half;            // 16th edge
					else
						state <= st_wait_edge;
				end
				st_last_half: state <= st_done;
				st_done:      state <= st_finish;
				st_finish:    state <= st_idle;
				default:      state <= st_idle;
			endcase
		end
	end

	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n)
			edge_cnt <= '0;
		else if (state == st_idle)
			edge_cnt <= '0;                               // fresh count each frame
		else if (state == st_edge)
			edge_cnt <= edge_cnt + 5'd1;
	end

	// miso: load at frame start, msb first
	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n)
			miso_shift <= '0;
		else if (state == st_idle && cs_active)
			miso_shift <= tx_byte;                        // tx register sampled here
		else if (shift_now)
			miso_shift <= {miso_shift[spi_bits_per_byte-2:0], 1'b0};
	end

	// mosi is stable for half a sclk period around the sample edge
	always_ff @(posedge sys_clk) begin
		if (sample_now)
			mosi_shift <= {mosi_shift[spi_bits_per_byte-2:0], mosi};
	end

	assign miso      = miso_shift[spi_bits_per_byte-1];
	assign rx_byte   = mosi_shift;                        // valid from byte_done on
	assign byte_done = (state == st_done);

	a_done_cnt: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		byte_done |-> edge_cnt == spi_edges_per_byte);

	a_idle_cs: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		!cs_active |=> state == st_idle);

endmodule

`default_nettype wire

/* logic/spi_wb_regs.sv */
// Wishbone classic register file for the SPI slave.
// Holds txdata, rxdata and status flags; ack one cycle after the request.
// irq follows rx_valid.
`default_nettype none

module spi_wb_regs (
	input  logic               sys_clk,
	input  logic               sys_rst_n,
	input  logic               wb_cyc,
	input  logic               wb_stb,
	input  logic               wb_we,
	input  wb_pkg::wb_adr_t    wb_adr,
	input  wb_pkg::wb_dat_t    wb_dat_w,
	output wb_pkg::wb_dat_t    wb_dat_r,
	output logic               wb_ack,
	output logic               irq,
	input  logic               byte_done,
	input  logic               cs_active,
	input  spi_pkg::spi_byte_t rx_byte,
	output spi_pkg::spi_byte_t tx_byte
);

	import wb_pkg::*;
	import spi_pkg::*;

	logic      req;                                       // new request this cycle
	logic      wr_en;
	logic      rd_en;
	logic      rx_clear;                                  // rxdata read
	logic      rx_valid;
	logic      overrun;
	spi_byte_t tx_data;
	spi_byte_t rx_data;
	wb_dat_t   status;
	wb_dat_t   rd_mux;

	// the ack cycle itself is not a new request
	assign req      = wb_cyc & wb_stb & ~wb_ack;
	assign wr_en    = req & wb_we;
	assign rd_en    = req & ~wb_we;
	assign rx_clear = rd_en && (wb_adr == reg_rxdata);

	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n)
			wb_ack <= 1'b0;
		else
			wb_ack <= req;                                // single cycle, no wait states
	end

	// write lands on the ack edge
	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n)
			tx_data <= '0;
		else if (wr_en && wb_adr == reg_txdata)
			tx_data <= wb_dat_w;
	end

	// receive side; SPI cannot stall so a new byte always wins
	always_ff @(posedge sys_clk) begin
		if (!sys_rst_n) begin
			rx_data  <= '0;
			rx_valid <= 1'b0;
			overrun  <= 1'b0;
		end else if (byte_done) begin
			rx_data  <= rx_byte;
			rx_valid <= 1'b1;
			overrun  <= rx_clear ? 1'b0 : (overrun | rx_valid); // unread byte dropped
		end else if (rx_clear) begin
			rx_valid <= 1'b0;
			overrun  <= 1'b0;
		end
	end

	always_comb begin
		status                = '0;
		status[stat_rx_valid] = rx_valid;
		status[stat_overrun]  = overrun;
		status[stat_busy]     = cs_active;                // frame in progress
	end

	always_comb begin
		case (wb_adr)
			reg_txdata: rd_mux = tx_data;
			reg_rxdata: rd_mux = rx_data;
			reg_status: rd_mux = status;
			default:    rd_mux = '0;                      // address 3
		endcase
	end

	// read data held through the ack cycle
	always_ff @(posedge sys_clk) begin
		if (rd_en)
			wb_dat_r <= rd_mux;
	end

	assign tx_byte = tx_data;
	assign irq     = rx_valid;

	a_ack_single: assert property (@(posedge sys_clk) disable iff (!sys_rst_n)
		wb_ack |=> !wb_ack);

endmodule

`default_nettype wire

/* logic/spi_wb_top.sv */
// SPI slave peripheral top level with a Wishbone classic host port.
// Wires the cs/sclk synchronizer, the byte shift engine and the registers.
`default_nettype none

module spi_wb_top #(
	parameter bit CPOL = 1'b1,                            // sclk idles high
	parameter bit CPHA = 1'b1                             // sample on trailing edge
) (
	input  logic            sys_clk,
	input  logic            sys_rst_n,
	input  logic            cs,                           // from external master
	input  logic            sclk,
	input  logic            mosi,
	output logic            miso,                         // pad ring does the tristate
	input  logic            wb_cyc,
	input  logic            wb_stb,
	input  logic            wb_we,
	input  wb_pkg::wb_adr_t wb_adr,
	input  wb_pkg::wb_dat_t wb_dat_w,
	output wb_pkg::wb_dat_t wb_dat_r,
	output logic            wb_ack,
	output logic            irq
);

	import spi_pkg::*;

	logic      cs_active;
	logic      frame_start;
	logic      frame_end;
	logic      sample_edge;
	logic      shift_edge;
	logic      byte_done;
	spi_byte_t tx_byte;                                   // regs to shifter
	spi_byte_t rx_byte;                                   // shifter to regs

	spi_edge_sync #(
		.CPOL (CPOL),
		.CPHA (CPHA)
	) u_edge_sync (
		.sys_clk     (sys_clk),
		.sys_rst_n   (sys_rst_n),
		.cs          (cs),
		.sclk        (sclk),
		.cs_active   (cs_active),
		.frame_start (frame_start),
		.frame_end   (frame_end),
		.sample_edge (sample_edge),
		.shift_edge  (shift_edge)
	);

	spi_slave #(
		.CPHA (CPHA)
	) u_spi_slave (
		.sys_clk     (sys_clk),
		.sys_rst_n   (sys_rst_n),
		.cs_active   (cs_active),
		.frame_start (frame_start),
		.frame_end   (frame_end),
		.sample_edge (sample_edge),
		.shift_edge  (shift_edge),
		.mosi        (mosi),
		.tx_byte     (tx_byte),
		.miso        (miso),
		.byte_done   (byte_done),
		.rx_byte     (rx_byte)
	);

	spi_wb_regs u_wb_regs (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.wb_cyc    (wb_cyc),
		.wb_stb    (wb_stb),
		.wb_we     (wb_we),
		.wb_adr    (wb_adr),
		.wb_dat_w  (wb_dat_w),
		.wb_dat_r  (wb_dat_r),
		.wb_ack    (wb_ack),
		.irq       (irq),
		.byte_done (byte_done),
		.cs_active (cs_active),
		.rx_byte   (rx_byte),
		.tx_byte   (tx_byte)
	);

endmodule

`default_nettype wire

/* logic/wb_pkg.sv */
// Wishbone side definitions: bus widths, register map and status bit layout.
// Used by the register file and by the top level port list.
`default_nettype none

package wb_pkg;

	// 4 byte-wide registers
	typedef logic [1:0] wb_adr_t;

	// 8-bit classic bus data
	typedef logic [7:0] wb_dat_t;

	// register map
	localparam wb_adr_t reg_txdata = 2'd0;                // r/w, byte sent in next frame
	localparam wb_adr_t reg_rxdata = 2'd1;                // ro, read clears rx_valid and overrun
	localparam wb_adr_t reg_status = 2'd2;                // ro, flags below
	// address 3 reads zero, writes dropped

	// status register bit positions
	localparam int stat_rx_valid = 0;                     // unread byte in rxdata
	localparam int stat_overrun = 1;                      // byte lost, sticky until rxdata read
	localparam int stat_busy = 2;                         // cs currently low

endpackage

`default_nettype wire

/* verification/tb_spi_wb_top.sv */
// Testbench for the SPI slave with its Wishbone host port.
// Walks a table of bus accesses and SPI frames (mode 3) and checks the
// results against a small model of the txdata/rxdata registers and flags.
`default_nettype none

module tb_spi_wb_top;

	timeunit 1ns;
	timeprecision 100ps;

	import spi_pkg::*;
	import wb_pkg::*;

	localparam int clk_period       = 4;                  // ns
	localparam int reset_cycles     = 8;
	localparam int half_period      = 10;                 // sclk half period in sys_clk cycles
	localparam int cs_gap           = 12;                 // cs high between frames
	localparam int ack_limit        = 8;
	localparam int entry_max_cycles = (2 * spi_bits_per_byte + 4) * half_period;

	typedef enum {op_write, op_read, op_status, op_xfer, op_abort} op_e;

	logic    sys_clk = 1'b0;
	logic    sys_rst_n;
	logic    cs;
	logic    sclk;
	logic    mosi;
	logic    miso;
	logic    wb_cyc;
	logic    wb_stb;
	logic    wb_we;
	wb_adr_t wb_adr;
	wb_dat_t wb_dat_w;
	wb_dat_t wb_dat_r;
	logic    wb_ack;
	logic    irq;

	// stimulus table with one entry per index
	string   names[$];
	op_e     ops[$];
	wb_adr_t adrs[$];
	wb_dat_t dats[$];
	bit      rnds[$];                                     // write data from lfsr
	bit      table_ready = 1'b0;

	// register model
	spi_byte_t   model_tx = '0;
	spi_byte_t   model_rx = '0;
	logic        model_valid = 1'b0;
	logic        model_ovr = 1'b0;
	logic [15:0] lfsr_state = 16'd6636;
	int          errors = 0;
	int          checks = 0;

	always #(clk_period / 2) sys_clk = ~sys_clk;

	spi_wb_top dut (
		.sys_clk   (sys_clk),
		.sys_rst_n (sys_rst_n),
		.cs        (cs),
		.sclk      (sclk),
		.mosi      (mosi),
		.miso      (miso),
		.wb_cyc    (wb_cyc),
		.wb_stb    (wb_stb),
		.wb_we     (wb_we),
		.wb_adr    (wb_adr),
		.wb_dat_w  (wb_dat_w),
		.wb_dat_r  (wb_dat_r),
		.wb_ack    (wb_ack),
		.irq       (irq)
	);

	// x^16 + x^14 + x^13 + x^11
	function automatic logic [15:0] lfsr_step(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	task automatic draw_byte(output spi_byte_t b);
		b = '0;
		for (int k = 0; k < spi_bits_per_byte; k++) begin
			lfsr_state = lfsr_step(lfsr_state);           // one step per bit
			b = {b[spi_bits_per_byte-2:0], lfsr_state[0]};
		end
	endtask

	function automatic wb_dat_t model_status();
		wb_dat_t s;
		s                = '0;                            // busy stays 0 between frames
		s[stat_rx_valid] = model_valid;
		s[stat_overrun]  = model_ovr;
		return s;
	endfunction

	task automatic check_byte(input string name, input spi_byte_t exp_val, input spi_byte_t act);
		checks++;
		if (act !== exp_val) begin
			errors++;
			$display("[FAIL] %s: expected %h, actual %h", name, exp_val, act);
		end
	endtask

	task automatic check_status(input string name, input wb_dat_t exp_val, input wb_dat_t act);
		checks++;
		if (act !== exp_val) begin
			errors++;
			$display("[FAIL] %s: expected %b, actual %b", name, exp_val, act);
		end
	endtask

	task automatic check_bit(input string name, input logic exp_val, input logic act);
		checks++;
		if (act !== exp_val) begin
			errors++;
			$display("[FAIL] %s: expected %b, actual %b", name, exp_val, act);
		end
	endtask

	task automatic wait_cycles(input int n);
		repeat (n) @(posedge sys_clk);
	endtask

	// one classic access that expects exactly one ack
	task automatic bus_cycle(input bit we, input wb_adr_t adr, input wb_dat_t wdat,
		output wb_dat_t rdat);
		int wait_cnt;
		wait_cnt = 0;
		wb_cyc   <= 1'b1;
		wb_stb   <= 1'b1;
		wb_we    <= we;
		wb_adr   <= adr;
		wb_dat_w <= wdat;
		do begin
			@(posedge sys_clk);
			wait_cnt++;
		end while (wb_ack !== 1'b1 && wait_cnt < ack_limit);
		if (wb_ack !== 1'b1) begin
			errors++;
			$display("no wb_ack within %0d cycles for address %0d", ack_limit, adr);
		end
		rdat   = wb_dat_r;                                // valid during ack
		wb_cyc <= 1'b0;
		wb_stb <= 1'b0;
		wb_we  <= 1'b0;
		@(posedge sys_clk);
		if (wb_ack !== 1'b0) begin
			errors++;
			$display("second wb_ack after access to address %0d", adr);
		end
	endtask

	task automatic wb_write(input wb_adr_t adr, input wb_dat_t wdat);
		wb_dat_t unused;
		bus_cycle(1'b1, adr, wdat, unused);
	endtask

	task automatic wb_read(input wb_adr_t adr, output wb_dat_t rdat);
		bus_cycle(1'b0, adr, '0, rdat);
	endtask

	// master for CPOL=1 CPHA=1
	// fewer than 8 bits gives an aborted frame
	task automatic spi_xfer(input spi_byte_t mosi_byte, input int n_bits,
		output spi_byte_t miso_byte);
		miso_byte = '0;
		cs <= 1'b0;
		wait_cycles(half_period);                         // slave loads tx byte
		for (int i = 0; i < n_bits; i++) begin
			sclk <= 1'b0;                                 // leading edge where slave shifts
			mosi <= mosi_byte[spi_bits_per_byte-1-i];
			wait_cycles(half_period);
			sclk <= 1'b1;                                 // trailing edge where both sample
			miso_byte = {miso_byte[spi_bits_per_byte-2:0], miso};
			wait_cycles(half_period);
		end
		cs <= 1'b1;
		wait_cycles(cs_gap);
	endtask

	task automatic add_entry(input string name, input op_e op, input wb_adr_t adr,
		input wb_dat_t dat, input bit rnd);
		names.push_back(name);
		ops.push_back(op);
		adrs.push_back(adr);
		dats.push_back(dat);
		rnds.push_back(rnd);
	endtask

	initial begin
		wait (table_ready);
		#(clk_period * (reset_cycles + 4 + names.size() * entry_max_cycles));
		$display("Timeout: the tests did not finish in the expected time");
		$display("Test failed");
		$finish;
	end

	initial begin
		wb_dat_t   rdat;
		wb_dat_t   wdat;
		spi_byte_t exp_byte;
		spi_byte_t mosi_byte;
		spi_byte_t miso_byte;

		sys_rst_n <= 1'b0;
		cs        <= 1'b1;
		sclk      <= 1'b1;                                // CPOL=1 idle
		mosi      <= 1'b0;
		wb_cyc    <= 1'b0;
		wb_stb    <= 1'b0;
		wb_we     <= 1'b0;
		wb_adr    <= '0;
		wb_dat_w  <= '0;

		add_entry("reset_status", op_status, reg_status, 8'h00, 1'b0);
		add_entry("reset_txdata", op_read, reg_txdata, 8'h00, 1'b0);
		add_entry("adr3_read", op_read, 2'd3, 8'h00, 1'b0);
		add_entry("adr3_write", op_write, 2'd3, 8'ha5, 1'b0);
		add_entry("adr3_readback", op_read, 2'd3, 8'h00, 1'b0);
		add_entry("status_write", op_write, reg_status, 8'hff, 1'b0);
		add_entry("status_readonly", op_status, reg_status, 8'h00, 1'b0);
		add_entry("dropped_writes_txdata", op_read, reg_txdata, 8'h00, 1'b0);
		add_entry("tx_fixed", op_write, reg_txdata, 8'h3c, 1'b0);
		add_entry("tx_fixed_readback", op_read, reg_txdata, 8'h00, 1'b0);
		add_entry("tx_rand", op_write, reg_txdata, 8'h00, 1'b1);
		add_entry("tx_rand_readback", op_read, reg_txdata, 8'h00, 1'b0);
		add_entry("xfer_single", op_xfer, reg_txdata, 8'h00, 1'b0);
		add_entry("single_status", op_status, reg_status, 8'h00, 1'b0);
		add_entry("single_rxdata", op_read, reg_rxdata, 8'h00, 1'b0);
		add_entry("single_cleared", op_status, reg_status, 8'h00, 1'b0);
		add_entry("tx_overrun", op_write, reg_txdata, 8'h00, 1'b1);
		add_entry("xfer_first", op_xfer, reg_txdata, 8'h00, 1'b0);
		add_entry("xfer_second", op_xfer, reg_txdata, 8'h00, 1'b0);
		add_entry("overrun_status", op_status, reg_status, 8'h00, 1'b0);
		add_entry("overrun_rxdata", op_read, reg_rxdata, 8'h00, 1'b0);
		add_entry("overrun_cleared", op_status, reg_status, 8'h00, 1'b0);
		add_entry("abort_3bit", op_abort, reg_txdata, 8'h00, 1'b0);
		add_entry("abort_status", op_status, reg_status, 8'h00, 1'b0);
		add_entry("tx_after_abort", op_write, reg_txdata, 8'h00, 1'b1);
		add_entry("xfer_after_abort", op_xfer, reg_txdata, 8'h00, 1'b0);
		add_entry("after_abort_status", op_status, reg_status, 8'h00, 1'b0);
		add_entry("after_abort_rxdata", op_read, reg_rxdata, 8'h00, 1'b0);
		add_entry("after_abort_cleared", op_status, reg_status, 8'h00, 1'b0);
		table_ready = 1'b1;

		wait_cycles(reset_cycles);
		sys_rst_n <= 1'b1;
		wait_cycles(2);

		for (int idx = 0; idx < names.size(); idx++) begin
			case (ops[idx])
				op_write: begin
					wdat = dats[idx];
					if (rnds[idx])
						draw_byte(wdat);
					wb_write(adrs[idx], wdat);
					if (adrs[idx] == reg_txdata)
						model_tx = wdat;                  // other addresses drop writes
				end
				op_read: begin
					wb_read(adrs[idx], rdat);
					case (adrs[idx])
						reg_txdata: exp_byte = model_tx;
						reg_rxdata: exp_byte = model_rx;
						default:    exp_byte = '0;
					endcase
					check_byte(names[idx], exp_byte, rdat);
					if (adrs[idx] == reg_rxdata) begin
						model_valid = 1'b0;               // read clears both flags
						model_ovr   = 1'b0;
					end
				end
				op_status: begin
					wb_read(reg_status, rdat);
					check_status(names[idx], model_status(), rdat);
					check_bit({names[idx], ".irq"}, model_valid, irq);
				end
				op_xfer: begin
					draw_byte(mosi_byte);
					spi_xfer(mosi_byte, spi_bits_per_byte, miso_byte);
					check_byte(names[idx], model_tx, miso_byte);
					model_ovr   = model_ovr | model_valid; // unread byte lost
					model_valid = 1'b1;
					model_rx    = mosi_byte;
				end
				default: begin
					draw_byte(mosi_byte);
					spi_xfer(mosi_byte, 3, miso_byte);    // flags must stay as they are
				end
			endcase
		end

		$display("checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

endmodule

`default_nettype wire
